// ==== hdl/rasterix_pkg.sv ====
`default_nettype none

package rasterix_pkg;

    // Screen geometry of the on-chip color buffer
    localparam int X_RESOLUTION = 16;
    localparam int Y_RESOLUTION = 8;
    localparam int X_WIDTH = $clog2(X_RESOLUTION);
    localparam int Y_WIDTH = $clog2(Y_RESOLUTION);
    localparam int PIXEL_COUNT = X_RESOLUTION * Y_RESOLUTION;
    localparam int INDEX_WIDTH = $clog2(PIXEL_COUNT);
    // One extra bit so an end coordinate equal to the resolution fits
    localparam int SCREEN_POS_WIDTH = X_WIDTH + 1;

    // RGB666 storage format
    localparam int SUB_PIXEL_WIDTH = 6;
    localparam int SUB_PIXEL_COUNT = 3;
    localparam int PIXEL_WIDTH = SUB_PIXEL_WIDTH * SUB_PIXEL_COUNT;

    // Stream widths
    localparam int CMD_WIDTH = 32;
    localparam int STREAM_PIXEL_WIDTH = 16;
    localparam int PIXEL_PER_BEAT = 4;
    localparam int DATA_WIDTH = STREAM_PIXEL_WIDTH * PIXEL_PER_BEAT;
    localparam int BEATS_PER_FRAME = PIXEL_COUNT / PIXEL_PER_BEAT;

    // Opcode field
    localparam int OP_POS = 28;
    localparam int OP_WIDTH = 4;

    localparam logic [OP_WIDTH-1:0] OP_SET_CLEAR_COLOR = 4'd1;
    localparam logic [OP_WIDTH-1:0] OP_SET_SCISSOR = 4'd3;
    localparam logic [OP_WIDTH-1:0] OP_SET_MASK = 4'd4;
    localparam logic [OP_WIDTH-1:0] OP_WRITE_PIXEL = 4'd5;
    localparam logic [OP_WIDTH-1:0] OP_COMMIT = 4'd6;
    localparam logic [OP_WIDTH-1:0] OP_MEMSET = 4'd7;
    localparam logic [OP_WIDTH-1:0] OP_SWAP = 4'd8;

    // Lowest bit of each command field
    localparam int COLOR_R_POS = 12;
    localparam int COLOR_G_POS = 6;
    localparam int COLOR_B_POS = 0;
    localparam int PIXEL_X_POS = 18;
    localparam int PIXEL_Y_POS = 22;
    localparam int SCISSOR_START_X_POS = 0;
    localparam int SCISSOR_START_Y_POS = 5;
    localparam int SCISSOR_END_X_POS = 10;
    localparam int SCISSOR_END_Y_POS = 15;
    localparam int SCISSOR_ENABLE_POS = 20;
    localparam int MASK_R_POS = 2;
    localparam int MASK_G_POS = 1;
    localparam int MASK_B_POS = 0;
    localparam int SWAP_VSYNC_POS = 0;

endpackage

`default_nettype wire

// ==== hdl/render_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module render_config_regs
(
    input  logic                                        aclk,
    input  logic                                        reset,

    input  logic                                        s_cmd_axis_tvalid,
    output logic                                        s_cmd_axis_tready,
    input  logic [rasterix_pkg::CMD_WIDTH-1:0]          s_cmd_axis_tdata,

    output logic [rasterix_pkg::PIXEL_WIDTH-1:0]        clear_color,
    output logic [rasterix_pkg::SUB_PIXEL_COUNT-1:0]    color_mask,
    output logic                                        scissor_enable,
    output logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_start_x,
    output logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_start_y,
    output logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_end_x,
    output logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_end_y,

    output logic                                        apply,
    input  logic                                        applied,
    output logic                                        cmd_memset,
    output logic                                        cmd_commit,

    output logic                                        pixel_wvalid,
    output logic [rasterix_pkg::X_WIDTH-1:0]            pixel_x,
    output logic [rasterix_pkg::Y_WIDTH-1:0]            pixel_y,
    output logic [rasterix_pkg::PIXEL_WIDTH-1:0]        pixel_wdata,

    output logic                                        swap_fb,
    output logic                                        swap_fb_enable_vsync,
    input  logic                                        fb_swapped
);
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_WAIT_APPLIED,
        ST_WAIT_SWAP
    } state_t;

    state_t                                     state;
    logic                                       cmd_accept;
    logic [rasterix_pkg::OP_WIDTH-1:0]          opcode;
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       cmd_color;

    assign s_cmd_axis_tready = (state == ST_IDLE);
    assign cmd_accept = s_cmd_axis_tvalid && s_cmd_axis_tready;
    assign opcode = s_cmd_axis_tdata[rasterix_pkg::OP_POS +: rasterix_pkg::OP_WIDTH];

    // Same color layout for clear color and pixel writes
    assign cmd_color = {
        s_cmd_axis_tdata[rasterix_pkg::COLOR_R_POS +: rasterix_pkg::SUB_PIXEL_WIDTH],
        s_cmd_axis_tdata[rasterix_pkg::COLOR_G_POS +: rasterix_pkg::SUB_PIXEL_WIDTH],
        s_cmd_axis_tdata[rasterix_pkg::COLOR_B_POS +: rasterix_pkg::SUB_PIXEL_WIDTH]
    };

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            apply <= 1'b0;
            cmd_memset <= 1'b0;
            cmd_commit <= 1'b0;
            pixel_wvalid <= 1'b0;
            swap_fb <= 1'b0;
            clear_color <= '0;
            color_mask <= '1;
            scissor_enable <= 1'b0;
        end
        else
        begin
            apply <= 1'b0;
            pixel_wvalid <= 1'b0;
            swap_fb <= 1'b0;
            if (cmd_accept)
            begin
                case (opcode)
                    rasterix_pkg::OP_SET_CLEAR_COLOR:
                        clear_color <= cmd_color;
                    rasterix_pkg::OP_SET_SCISSOR:
                        scissor_enable <= s_cmd_axis_tdata[rasterix_pkg::SCISSOR_ENABLE_POS];
                    rasterix_pkg::OP_SET_MASK:
                        color_mask <= {s_cmd_axis_tdata[rasterix_pkg::MASK_R_POS],
                                       s_cmd_axis_tdata[rasterix_pkg::MASK_G_POS],
                                       s_cmd_axis_tdata[rasterix_pkg::MASK_B_POS]};
                    rasterix_pkg::OP_WRITE_PIXEL:
                        pixel_wvalid <= 1'b1;
                    rasterix_pkg::OP_COMMIT, rasterix_pkg::OP_MEMSET:
                    begin
                        apply <= 1'b1;
                        cmd_commit <= (opcode == rasterix_pkg::OP_COMMIT);
                        cmd_memset <= (opcode == rasterix_pkg::OP_MEMSET);
                        state <= ST_WAIT_APPLIED;
                    end
                    rasterix_pkg::OP_SWAP:
                    begin
                        swap_fb <= 1'b1;
                        state <= ST_WAIT_SWAP;
                    end
                    // Unknown opcodes are consumed without effect
                    default:
                    begin
                    end
                endcase
            end
            // applied still reports idle during the apply cycle itself
            else if ((state == ST_WAIT_APPLIED) && !apply && applied)
                state <= ST_IDLE;
            else if ((state == ST_WAIT_SWAP) && fb_swapped)
                state <= ST_IDLE;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (cmd_accept && (opcode == rasterix_pkg::OP_SET_SCISSOR))
        begin
            scissor_start_x <= s_cmd_axis_tdata[rasterix_pkg::SCISSOR_START_X_POS +:
                                                rasterix_pkg::SCREEN_POS_WIDTH];
            scissor_start_y <= s_cmd_axis_tdata[rasterix_pkg::SCISSOR_START_Y_POS +:
                                                rasterix_pkg::SCREEN_POS_WIDTH];
            scissor_end_x <= s_cmd_axis_tdata[rasterix_pkg::SCISSOR_END_X_POS +:
                                              rasterix_pkg::SCREEN_POS_WIDTH];
            scissor_end_y <= s_cmd_axis_tdata[rasterix_pkg::SCISSOR_END_Y_POS +:
                                              rasterix_pkg::SCREEN_POS_WIDTH];
        end
        if (cmd_accept && (opcode == rasterix_pkg::OP_WRITE_PIXEL))
        begin
            pixel_x <= s_cmd_axis_tdata[rasterix_pkg::PIXEL_X_POS +: rasterix_pkg::X_WIDTH];
            pixel_y <= s_cmd_axis_tdata[rasterix_pkg::PIXEL_Y_POS +: rasterix_pkg::Y_WIDTH];
            pixel_wdata <= cmd_color;
        end
        if (cmd_accept && (opcode == rasterix_pkg::OP_SWAP))
            swap_fb_enable_vsync <= s_cmd_axis_tdata[rasterix_pkg::SWAP_VSYNC_POS];
    end

endmodule

`default_nettype wire

// ==== hdl/internal_framebuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module internal_framebuffer
(
    input  logic                                        aclk,
    input  logic                                        reset,

    input  logic [rasterix_pkg::PIXEL_WIDTH-1:0]        clear_color,
    input  logic [rasterix_pkg::SUB_PIXEL_COUNT-1:0]    color_mask,
    input  logic                                        scissor_enable,
    input  logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_start_x,
    input  logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_start_y,
    input  logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_end_x,
    input  logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]   scissor_end_y,

    input  logic                                        apply,
    output logic                                        applied,
    input  logic                                        cmd_memset,
    input  logic                                        cmd_commit,

    input  logic                                        pixel_wvalid,
    input  logic [rasterix_pkg::X_WIDTH-1:0]            pixel_x,
    input  logic [rasterix_pkg::Y_WIDTH-1:0]            pixel_y,
    input  logic [rasterix_pkg::PIXEL_WIDTH-1:0]        pixel_wdata,

    output logic                                        pix_valid,
    input  logic                                        pix_ready,
    output logic                                        pix_last,
    output logic [rasterix_pkg::PIXEL_WIDTH-1:0]        pix_data
);
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       mem [rasterix_pkg::PIXEL_COUNT];
    logic                                       busy;
    logic [rasterix_pkg::INDEX_WIDTH-1:0]       idx;
    logic                                       memset_active;
    logic                                       rd_en;

    logic                                       wr_en;
    logic [rasterix_pkg::INDEX_WIDTH-1:0]       wr_idx;
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       wr_data;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  wr_pos_x;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  wr_pos_y;
    logic                                       wr_inside;
    logic [rasterix_pkg::SUB_PIXEL_COUNT-1:0]   wr_strb;

    assign applied = !busy;
    assign memset_active = busy && cmd_memset;

    // Load the output register unless it holds an unsent pixel or the final one
    assign rd_en = busy && cmd_commit && !(pix_valid && pix_last) && (!pix_valid || pix_ready);

    // Memset owns the write port while busy, pixel writes only arrive when idle
    assign wr_en = memset_active || pixel_wvalid;
    assign wr_idx = memset_active ? idx : {pixel_y, pixel_x};
    assign wr_data = memset_active ? clear_color : pixel_wdata;

    // Index is y * 16 + x, so x and y fall out of the index bits
    assign wr_pos_x = {{(rasterix_pkg::SCREEN_POS_WIDTH - rasterix_pkg::X_WIDTH){1'b0}},
                       wr_idx[rasterix_pkg::X_WIDTH-1:0]};
    assign wr_pos_y = {{(rasterix_pkg::SCREEN_POS_WIDTH - rasterix_pkg::Y_WIDTH){1'b0}},
                       wr_idx[rasterix_pkg::INDEX_WIDTH-1:rasterix_pkg::X_WIDTH]};

    assign wr_inside = !scissor_enable
                       || ((scissor_start_x <= wr_pos_x) && (wr_pos_x < scissor_end_x)
                           && (scissor_start_y <= wr_pos_y) && (wr_pos_y < scissor_end_y));

    assign wr_strb = {rasterix_pkg::SUB_PIXEL_COUNT{wr_en && wr_inside}} & color_mask;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            idx <= '0;
            pix_valid <= 1'b0;
        end
        else
        begin
            if (apply)
            begin
                busy <= 1'b1;
                idx <= '0;
            end
            else if (memset_active)
            begin
                idx <= idx + 1'b1;
                if (int'(idx) == rasterix_pkg::PIXEL_COUNT - 1)
                    busy <= 1'b0;
            end
            else if (rd_en)
                idx <= idx + 1'b1;

            // Commit ends once the final pixel is handed over
            if (busy && cmd_commit && pix_valid && pix_ready && pix_last)
                busy <= 1'b0;

            if (rd_en)
                pix_valid <= 1'b1;
            else if (pix_ready)
                pix_valid <= 1'b0;
        end
    end

    // Channel 0 is blue and matches mask bit 0
    always_ff @(posedge aclk)
    begin
        for (int c = 0; c < rasterix_pkg::SUB_PIXEL_COUNT; c++)
        begin
            if (wr_strb[c])
                mem[wr_idx][c*rasterix_pkg::SUB_PIXEL_WIDTH +: rasterix_pkg::SUB_PIXEL_WIDTH]
                    <= wr_data[c*rasterix_pkg::SUB_PIXEL_WIDTH +: rasterix_pkg::SUB_PIXEL_WIDTH];
        end
        if (rd_en)
        begin
            pix_data <= mem[idx];
            pix_last <= (int'(idx) == rasterix_pkg::PIXEL_COUNT - 1);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rgb565_beat_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgb565_beat_packer
(
    input  logic                                        aclk,
    input  logic                                        reset,

    input  logic                                        pix_valid,
    output logic                                        pix_ready,
    input  logic                                        pix_last,
    input  logic [rasterix_pkg::PIXEL_WIDTH-1:0]        pix_data,

    output logic                                        m_framebuffer_axis_tvalid,
    input  logic                                        m_framebuffer_axis_tready,
    output logic                                        m_framebuffer_axis_tlast,
    output logic [rasterix_pkg::DATA_WIDTH-1:0]         m_framebuffer_axis_tdata
);
    logic [$clog2(rasterix_pkg::PIXEL_PER_BEAT)-1:0]    slot;
    logic                                               pix_accept;
    logic [rasterix_pkg::STREAM_PIXEL_WIDTH-1:0]        rgb565;

    // No shifting while a full beat waits, so tdata stays stable
    assign pix_ready = !m_framebuffer_axis_tvalid;
    assign pix_accept = pix_valid && pix_ready;

    // Red and blue lose their LSB, green keeps all six bits
    assign rgb565 = {
        pix_data[rasterix_pkg::PIXEL_WIDTH-1 -: rasterix_pkg::SUB_PIXEL_WIDTH-1],
        pix_data[rasterix_pkg::SUB_PIXEL_WIDTH +: rasterix_pkg::SUB_PIXEL_WIDTH],
        pix_data[rasterix_pkg::SUB_PIXEL_WIDTH-1 -: rasterix_pkg::SUB_PIXEL_WIDTH-1]
    };

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            slot <= '0;
            m_framebuffer_axis_tvalid <= 1'b0;
        end
        else
        begin
            if (m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
                m_framebuffer_axis_tvalid <= 1'b0;
            if (pix_accept)
            begin
                slot <= slot + 1'b1;
                if (int'(slot) == rasterix_pkg::PIXEL_PER_BEAT - 1)
                    m_framebuffer_axis_tvalid <= 1'b1;
            end
        end
    end

    // First pixel ends up in the lowest slot after four shifts
    always_ff @(posedge aclk)
    begin
        if (pix_accept)
        begin
            m_framebuffer_axis_tdata <= {rgb565,
                m_framebuffer_axis_tdata[rasterix_pkg::DATA_WIDTH-1:
                                         rasterix_pkg::STREAM_PIXEL_WIDTH]};
            // Last flag of the fourth pixel is the one that sticks
            m_framebuffer_axis_tlast <= pix_last;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rasterix_core_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module rasterix_core_if
(
    input  logic                                    aclk,
    input  logic                                    reset,

    input  logic                                    s_cmd_axis_tvalid,
    output logic                                    s_cmd_axis_tready,
    input  logic [rasterix_pkg::CMD_WIDTH-1:0]      s_cmd_axis_tdata,

    output logic                                    m_framebuffer_axis_tvalid,
    input  logic                                    m_framebuffer_axis_tready,
    output logic                                    m_framebuffer_axis_tlast,
    output logic [rasterix_pkg::DATA_WIDTH-1:0]     m_framebuffer_axis_tdata,

    output logic                                    swap_fb,
    output logic                                    swap_fb_enable_vsync,
    input  logic                                    fb_swapped
);
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       clear_color;
    logic [rasterix_pkg::SUB_PIXEL_COUNT-1:0]   color_mask;
    logic                                       scissor_enable;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  scissor_start_x;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  scissor_start_y;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  scissor_end_x;
    logic [rasterix_pkg::SCREEN_POS_WIDTH-1:0]  scissor_end_y;
    logic                                       apply;
    logic                                       applied;
    logic                                       cmd_memset;
    logic                                       cmd_commit;
    logic                                       pixel_wvalid;
    logic [rasterix_pkg::X_WIDTH-1:0]           pixel_x;
    logic [rasterix_pkg::Y_WIDTH-1:0]           pixel_y;
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       pixel_wdata;

    // Internal RGB666 pixel stream
    logic                                       pix_valid;
    logic                                       pix_ready;
    logic                                       pix_last;
    logic [rasterix_pkg::PIXEL_WIDTH-1:0]       pix_data;

    render_config_regs render_config_regs_inst (
        .aclk                 (aclk),
        .reset                (reset),
        .s_cmd_axis_tvalid    (s_cmd_axis_tvalid),
        .s_cmd_axis_tready    (s_cmd_axis_tready),
        .s_cmd_axis_tdata     (s_cmd_axis_tdata),
        .clear_color          (clear_color),
        .color_mask           (color_mask),
        .scissor_enable       (scissor_enable),
        .scissor_start_x      (scissor_start_x),
        .scissor_start_y      (scissor_start_y),
        .scissor_end_x        (scissor_end_x),
        .scissor_end_y        (scissor_end_y),
        .apply                (apply),
        .applied              (applied),
        .cmd_memset           (cmd_memset),
        .cmd_commit           (cmd_commit),
        .pixel_wvalid         (pixel_wvalid),
        .pixel_x              (pixel_x),
        .pixel_y              (pixel_y),
        .pixel_wdata          (pixel_wdata),
        .swap_fb              (swap_fb),
        .swap_fb_enable_vsync (swap_fb_enable_vsync),
        .fb_swapped           (fb_swapped)
    );

    internal_framebuffer internal_framebuffer_inst (
        .aclk            (aclk),
        .reset           (reset),
        .clear_color     (clear_color),
        .color_mask      (color_mask),
        .scissor_enable  (scissor_enable),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .apply           (apply),
        .applied         (applied),
        .cmd_memset      (cmd_memset),
        .cmd_commit      (cmd_commit),
        .pixel_wvalid    (pixel_wvalid),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .pixel_wdata     (pixel_wdata),
        .pix_valid       (pix_valid),
        .pix_ready       (pix_ready),
        .pix_last        (pix_last),
        .pix_data        (pix_data)
    );

    rgb565_beat_packer rgb565_beat_packer_inst (
        .aclk                      (aclk),
        .reset                     (reset),
        .pix_valid                 (pix_valid),
        .pix_ready                 (pix_ready),
        .pix_last                  (pix_last),
        .pix_data                  (pix_data),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata)
    );

endmodule

`default_nettype wire

// ==== sim/tb_rasterix_core_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rasterix_core_if;

    localparam int MAX_CYCLES = 40000;
    localparam int BEATS = rasterix_pkg::BEATS_PER_FRAME;
    localparam int PIXELS = rasterix_pkg::PIXEL_COUNT;
    localparam logic [31:0] SEED = 32'h2ec7_5586;

    logic                                   aclk;
    logic                                   reset;
    logic                                   s_cmd_axis_tvalid;
    logic                                   s_cmd_axis_tready;
    logic [rasterix_pkg::CMD_WIDTH-1:0]     s_cmd_axis_tdata;
    logic                                   m_framebuffer_axis_tvalid;
    logic                                   m_framebuffer_axis_tready;
    logic                                   m_framebuffer_axis_tlast;
    logic [rasterix_pkg::DATA_WIDTH-1:0]    m_framebuffer_axis_tdata;
    logic                                   swap_fb;
    logic                                   swap_fb_enable_vsync;
    logic                                   fb_swapped;

    logic [31:0]    lfsr_state;
    logic [31:0]    ready_lfsr_state;
    logic           ready_random;
    int             cycles = 0;
    int             swap_pulses;
    logic           expected_vsync;
    logic           held;
    logic [64:0]    held_beat;
    // Every accepted beat as {tlast, tdata}
    logic [64:0]    beats [$];
    int             frame_base;

    // Reference model of the color buffer and its configuration
    logic [17:0]    model_mem [PIXELS];
    logic [17:0]    model_clear;
    logic [2:0]     model_mask;
    logic           sc_en;
    int             sc_sx;
    int             sc_sy;
    int             sc_ex;
    int             sc_ey;

    rasterix_core_if rasterix_core_if_inst (
        .aclk                      (aclk),
        .reset                     (reset),
        .s_cmd_axis_tvalid         (s_cmd_axis_tvalid),
        .s_cmd_axis_tready         (s_cmd_axis_tready),
        .s_cmd_axis_tdata          (s_cmd_axis_tdata),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata),
        .swap_fb                   (swap_fb),
        .swap_fb_enable_vsync      (swap_fb_enable_vsync),
        .fb_swapped                (fb_swapped)
    );

    always #5 aclk = ~aclk;

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] random_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        logic lsb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb = state[0];
            state = state >> 1;
            if (lsb)
                state = state ^ 32'h8020_0003;
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic logic [15:0] to_rgb565(input logic [17:0] color);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        red = color[17:12];
        green = color[11:6];
        blue = color[5:0];
        return {red[5:1], green, blue[5:1]};
    endfunction

    function automatic logic inside_scissor(input int x, input int y);
        return !sc_en || ((sc_sx <= x) && (x < sc_ex) && (sc_sy <= y) && (y < sc_ey));
    endfunction

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // Index is y * 16 + x
    task automatic model_write(input logic [6:0] index, input logic [17:0] color);
        if (inside_scissor(int'(index[3:0]), int'(index[6:4])))
        begin
            if (model_mask[2])
                model_mem[index][17:12] = color[17:12];
            if (model_mask[1])
                model_mem[index][11:6] = color[11:6];
            if (model_mask[0])
                model_mem[index][5:0] = color[5:0];
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_command(input logic [31:0] word);
        int gap;
        gap = int'(random_bits(lfsr_state, 2));
        repeat (gap)
        begin
            @(posedge aclk);
            #1;
        end
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata = word;
        do
            @(posedge aclk);
        while (!s_cmd_axis_tready);
        #1;
        s_cmd_axis_tvalid = 1'b0;
    endtask

    task automatic set_clear_color();
        model_clear = 18'(random_bits(lfsr_state, 18));
        send_command({rasterix_pkg::OP_SET_CLEAR_COLOR, 10'd0, model_clear});
    endtask

    task automatic set_mask(input logic [2:0] mask);
        model_mask = mask;
        send_command({rasterix_pkg::OP_SET_MASK, 25'd0, mask});
    endtask

    task automatic set_scissor(input logic en);
        sc_en = en;
        sc_sx = int'(random_bits(lfsr_state, 4));
        sc_sy = int'(random_bits(lfsr_state, 3));
        sc_ex = sc_sx + 1 + int'(random_bits(lfsr_state, 4));
        sc_ey = sc_sy + 1 + int'(random_bits(lfsr_state, 3));
        send_command({rasterix_pkg::OP_SET_SCISSOR, 7'd0, en,
                      5'(sc_ey), 5'(sc_ex), 5'(sc_sy), 5'(sc_sx)});
    endtask

    task automatic write_random_pixel();
        logic [3:0] x;
        logic [2:0] y;
        logic [17:0] color;
        x = 4'(random_bits(lfsr_state, 4));
        y = 3'(random_bits(lfsr_state, 3));
        color = 18'(random_bits(lfsr_state, 18));
        send_command({rasterix_pkg::OP_WRITE_PIXEL, 3'd0, y, x, color});
        model_write({y, x}, color);
    endtask

    task automatic run_memset();
        send_command({rasterix_pkg::OP_MEMSET, 28'd0});
        for (int i = 0; i < PIXELS; i++)
            model_write(7'(i), model_clear);
    endtask

    task automatic check_frame(input string label);
        logic [63:0] expected;
        while (beats.size() < frame_base + BEATS)
            @(posedge aclk);
        repeat (8)
            @(posedge aclk);
        #1;
        assert (beats.size() == frame_base + BEATS)
            else report_error($sformatf("%s has %0d beats", label, beats.size() - frame_base));
        for (int b = 0; b < BEATS; b++)
        begin
            expected = '0;
            for (int k = 0; k < 4; k++)
                expected = expected | (64'(to_rgb565(model_mem[7'(b * 4 + k)])) << (16 * k));
            assert (beats[frame_base + b][63:0] == expected)
                else report_error($sformatf("%s beat %0d is %h, expected %h", label, b,
                                            beats[frame_base + b][63:0], expected));
            assert (beats[frame_base + b][64] == (b == BEATS - 1))
                else report_error($sformatf("%s beat %0d has wrong tlast", label, b));
        end
        frame_base = frame_base + BEATS;
    endtask

    task automatic run_commit(input string label);
        send_command({rasterix_pkg::OP_COMMIT, 28'd0});
        check_frame(label);
    endtask

    task automatic run_swap();
        logic [3:0] x;
        logic [2:0] y;
        logic [17:0] color;
        int delay;
        x = 4'(random_bits(lfsr_state, 4));
        y = 3'(random_bits(lfsr_state, 3));
        color = ~model_mem[{y, x}];
        expected_vsync = (random_bits(lfsr_state, 1) != 32'd0);
        send_command({rasterix_pkg::OP_SWAP, 27'd0, expected_vsync});
        // The pixel write waits at the port until the swap is acknowledged
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata = {rasterix_pkg::OP_WRITE_PIXEL, 3'd0, y, x, color};
        delay = 1 + int'(random_bits(lfsr_state, 3));
        repeat (delay)
        begin
            @(posedge aclk);
            assert (!s_cmd_axis_tready)
                else report_error("command accepted before fb_swapped");
        end
        #1;
        fb_swapped = 1'b1;
        @(posedge aclk);
        assert (!s_cmd_axis_tready)
            else report_error("command accepted in the fb_swapped cycle");
        #1;
        fb_swapped = 1'b0;
        do
            @(posedge aclk);
        while (!s_cmd_axis_tready);
        #1;
        s_cmd_axis_tvalid = 1'b0;
        model_write({y, x}, color);
        run_commit("frame after swap");
        assert (swap_pulses == 1)
            else report_error($sformatf("%0d swap_fb pulses for one swap", swap_pulses));
    endtask

    // Output back-pressure that is either always ready or random
    initial
    begin
        m_framebuffer_axis_tready = 1'b1;
        ready_lfsr_state = SEED;
        forever
        begin
            @(posedge aclk);
            #1;
            if (ready_random)
                m_framebuffer_axis_tready = (random_bits(ready_lfsr_state, 1) != 32'd0);
            else
                m_framebuffer_axis_tready = 1'b1;
        end
    end

    // Collects beats, checks hold under back-pressure and counts swap pulses
    always @(posedge aclk)
    begin
        if (reset)
        begin
            held = 1'b0;
            swap_pulses = 0;
        end
        else
        begin
            if (held)
                assert (m_framebuffer_axis_tvalid
                        && ({m_framebuffer_axis_tlast, m_framebuffer_axis_tdata} == held_beat))
                    else report_error("framebuffer beat changed while tready was low");
            if (m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
                beats.push_back({m_framebuffer_axis_tlast, m_framebuffer_axis_tdata});
            held = m_framebuffer_axis_tvalid && !m_framebuffer_axis_tready;
            held_beat = {m_framebuffer_axis_tlast, m_framebuffer_axis_tdata};
            if (swap_fb)
            begin
                swap_pulses++;
                assert (swap_fb_enable_vsync == expected_vsync)
                    else report_error("swap_fb_enable_vsync differs from command bit 0");
            end
        end
    end

    // About 14 commits and 5 memsets need a few thousand cycles at most
    always @(posedge aclk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timeout");
        end
    end

    initial
    begin
        aclk = 1'b0;
        reset = 1'b1;
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tdata = '0;
        fb_swapped = 1'b0;
        lfsr_state = SEED;
        ready_random = 1'b0;
        expected_vsync = 1'b0;
        frame_base = 0;
        model_clear = '0;
        model_mask = 3'b111;
        sc_en = 1'b0;
        sc_sx = 0;
        sc_sy = 0;
        sc_ex = 0;
        sc_ey = 0;
        repeat (5)
            @(posedge aclk);
        #1;
        reset = 1'b0;
        @(posedge aclk);
        assert (!m_framebuffer_axis_tvalid && !swap_fb && s_cmd_axis_tready)
            else report_error("wrong output levels after reset");
        #1;

        // Full clear of the buffer, then readout
        set_clear_color();
        run_memset();
        run_commit("memset frame");

        for (int round = 0; round < 4; round++)
        begin
            ready_random = 1'b0;
            set_scissor(random_bits(lfsr_state, 1) != 32'd0);
            set_mask(3'(random_bits(lfsr_state, 3)));
            // Unused opcode has no effect
            send_command({4'hf, 28'(random_bits(lfsr_state, 28))});
            for (int i = 0; i < 16; i++)
                write_random_pixel();
            run_commit("pixel frame");

            // Same content again under random back-pressure
            ready_random = 1'b1;
            run_commit("stalled frame");

            // Clear restricted to a rectangle and some channels
            set_clear_color();
            set_scissor(1'b1);
            set_mask(3'(32'd1 + random_bits(lfsr_state, 3) % 32'd6));
            run_memset();
            run_commit("scissored memset frame");
        end

        set_scissor(1'b0);
        set_mask(3'b111);
        run_swap();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/rasterix_pkg.sv
hdl/render_config_regs.sv
hdl/internal_framebuffer.sv
hdl/rgb565_beat_packer.sv
hdl/rasterix_core_if.sv
sim/tb_rasterix_core_if.sv

// ==== Makefile ====
TOP = tb_rasterix_core_if

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

# Pass only when the simulation output holds the pass line
sim:
	verilator --binary --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
